// File: test/core_stimulus.txt
// Section header: group_size count. Then one line per instruction: inst_word expected.
// inst_word is {opcode, dest, imm_a, imm_b}; expected is {writes_reg, dest, value}.
1 5
04C832 2296
480A0A 25FB
8FE0FF 26F0
D0060D 2860
000E08 000F
3 6
140201 2A02
5A0001 2CFF
DFFE07 2F80
A2AAAA 3000
27FE02 3201
400603 0000
3 C
040300 2301
080500 2502
0C0700 2703
100900 2904
140B00 2B05
180D00 2D06
1C0F00 2F07
201100 3108
241300 3309
281500 350A
2C1700 370B
301900 390C
0 0

// File: all.f
common/core_pkg.sv
rtl/dispatch_decode.sv
rtl/exec_lanes.sv
rob/reorder_buffer.sv
rtl/core_top.sv
test/clock_gen.sv
test/core_sva.sv
test/core_tb.sv

// File: Bender.yml
package:
  name: rob_core

sources:
  - common/core_pkg.sv
  - rtl/dispatch_decode.sv
  - rtl/exec_lanes.sv
  - rob/reorder_buffer.sv
  - rtl/core_top.sv
  - target: test
    files:
      - test/clock_gen.sv
      - test/core_sva.sv
      - test/core_tb.sv

// File: test/core_tb.sv
`timescale 1ns/1ps

module core_tb;

	logic clock;
	logic reset;
	logic [core_pkg::WIDTH-1:0] inst_valid;
	core_pkg::inst_word_t [core_pkg::WIDTH-1:0] inst;
	logic [core_pkg::WIDTH-1:0] stall;
	core_pkg::retire_t [core_pkg::WIDTH-1:0] retire;

	logic [23:0] stim [0:255];
	core_pkg::inst_word_t pending [$];
	logic [13:0] expected [$];
	string current_test;
	string file_tests [3] = '{"single_ops", "wide_groups", "stall_stream"};
	int errors;
	int errors_at_start;
	int tests_run;
	int tests_failed;
	int retired_count;
	int dispatched_count;
	logic stall_seen;

	clock_gen u_clock (
		.clock(clock),
		.reset(reset)
	);

	core_top DUT (
		.clock(clock),
		.reset(reset),
		.inst_valid(inst_valid),
		.inst(inst),
		.stall(stall),
		.retire(retire)
	);

	task automatic check_value(input string name, input logic [31:0] expected_value,
			input logic [31:0] actual_value);
		if (expected_value !== actual_value) begin
			$display("[ERROR] %s: expected %0h, actual %0h", name, expected_value, actual_value);
			errors++;
		end
	endtask

	// Reference ALU, straight from the opcode rules.
	function automatic logic [13:0] model_retire(input core_pkg::inst_word_t w);
		logic [8:0] result;
		case (w.opcode)
			2'd0: result = w.imm_a + w.imm_b;
			2'd1: result = w.imm_a - w.imm_b;
			2'd2: result = w.imm_a & w.imm_b;
			default: result = w.imm_a << w.imm_b[2:0];
		endcase
		return {w.dest != 4'd0, w.dest, result};
	endfunction

	task automatic start_test(input string name);
		current_test = name;
		errors_at_start = errors;
		retired_count = 0;
		dispatched_count = 0;
		stall_seen = 1'b0;
	endtask

	task automatic end_test();
		tests_run++;
		if (errors > errors_at_start) begin
			tests_failed++;
			$display("Test %s: failed with %0d errors", current_test, errors - errors_at_start);
		end else begin
			$display("Test %s: ok", current_test);
		end
		expected.delete();
	endtask

	task automatic wait_reset_done();
		int guard;
		guard = 0;
		while (reset !== 1'b0 && guard < 50) begin
			@(posedge clock);
			guard++;
		end
		if (reset !== 1'b0) begin
			$display("Reset never deasserted within 50 cycles");
			errors++;
		end
		@(posedge clock);
		#5;
	endtask

	// Presents the oldest pending instructions and keeps the stalled ones.
	task automatic drive_pending(input int group);
		int n;
		int taken;
		int guard;
		guard = 0;
		while (pending.size() > 0 && guard < 2000) begin
			n = (pending.size() < group) ? pending.size() : group;
			for (int i = 0; i < core_pkg::WIDTH; i++) begin
				inst_valid[i] = (i < n);
				if (i < n) begin
					inst[i] = pending[i];
				end else begin
					inst[i] = '0;
				end
			end
			@(negedge clock);
			taken = 0;
			for (int i = 0; i < n; i++) begin
				if (!stall[i]) begin
					taken++;
				end
			end
			for (int i = 0; i < taken; i++) begin
				void'(pending.pop_front());
			end
			dispatched_count += taken;
			@(posedge clock);
			#5;
			guard++;
		end
		inst_valid = '0;
		inst = '0;
		if (pending.size() > 0) begin
			$display("Test %s: dispatch timed out with %0d instructions never accepted",
				current_test, pending.size());
			errors++;
			pending.delete();
		end
	endtask

	task automatic wait_retired(input int total);
		int guard;
		guard = 0;
		while (retired_count < total && guard < 500) begin
			@(posedge clock);
			guard++;
		end
		if (retired_count < total) begin
			$display("Test %s: timed out waiting for retirement, %0d of %0d retired",
				current_test, retired_count, total);
			errors++;
		end
		// A few more cycles to catch duplicates.
		repeat (5) @(posedge clock);
		#5;
		check_value({current_test, " dispatched"}, total, dispatched_count);
		check_value({current_test, " retired"}, total, retired_count);
	endtask

	// Retirement monitor, sampled mid-cycle.
	always @(negedge clock) begin
		logic [13:0] got;
		if (!reset) begin
			if (stall != '0) begin
				stall_seen = 1'b1;
			end
			for (int i = 0; i < core_pkg::WIDTH; i++) begin
				if (retire[i].valid) begin
					got = {retire[i].writes_reg, retire[i].dest, retire[i].value};
					if (expected.size() == 0) begin
						$display("Test %s: an instruction retired that was never expected",
							current_test);
						errors++;
					end else begin
						check_value(current_test, expected.pop_front(), got);
					end
					retired_count++;
				end
			end
		end
	end

	initial begin
		int ptr;
		int sec;
		int group;
		int count;
		logic [31:0] raw;
		core_pkg::inst_word_t w;
		inst_valid = '0;
		inst = '0;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		current_test = "reset";
		$readmemh("test/core_stimulus.txt", stim);
		void'($urandom(36630));
		wait_reset_done();

		start_test("idle");
		repeat (20) begin
			@(negedge clock);
			check_value("idle stall", 0, stall);
			check_value("idle retire", 0, {retire[2].valid, retire[1].valid, retire[0].valid});
		end
		end_test();

		ptr = 0;
		sec = 0;
		group = stim[ptr];
		count = stim[ptr + 1];
		ptr += 2;
		while (group != 0 && sec < 3) begin
			start_test(file_tests[sec]);
			for (int i = 0; i < count; i++) begin
				pending.push_back(stim[ptr]);
				expected.push_back(stim[ptr + 1][13:0]);
				ptr += 2;
			end
			@(posedge clock);
			#5;
			drive_pending(group);
			wait_retired(count);
			if (sec == 2) begin
				check_value("stall_stream stall seen", 1, stall_seen);
			end
			end_test();
			sec++;
			group = stim[ptr];
			count = stim[ptr + 1];
			ptr += 2;
		end

		start_test("random_run");
		for (int i = 0; i < 200; i++) begin
			raw = $urandom();
			w = raw[23:0];
			pending.push_back(w);
			expected.push_back(model_retire(w));
		end
		drive_pending(3);
		wait_retired(200);
		end_test();

		$display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

// File: test/core_sva.sv
`timescale 1ns/1ps

module core_sva (
	input logic clock,
	input logic reset,
	input core_pkg::rob_cnt_t count,
	input logic [1:0] alloc_count,
	input logic [core_pkg::WIDTH-1:0] stall,
	input core_pkg::retire_t [core_pkg::WIDTH-1:0] retire
);

	logic [core_pkg::WIDTH-1:0] retire_valid;
	logic [core_pkg::WIDTH-1:0] request_mask;
	logic [core_pkg::WIDTH-1:0] stall_aligned;

	always_comb begin
		for (int i = 0; i < core_pkg::WIDTH; i++) begin
			retire_valid[i] = retire[i].valid;
		end
	end

	// Requested slots, and the stall vector moved up to slot 2.
	always_comb begin
		for (int i = 0; i < core_pkg::WIDTH; i++) begin
			request_mask[i] = (i < alloc_count);
		end
		stall_aligned = stall << (core_pkg::WIDTH - alloc_count);
	end

	assert property (@(posedge clock) disable iff (reset) count <= core_pkg::ROB_DEPTH)
		else $error("ROB occupancy %0d exceeds depth", count);

	// Retire fills from slot 0 upward and never passes the occupancy.
	assert property (@(posedge clock) disable iff (reset)
		(retire_valid inside {3'b000, 3'b001, 3'b011, 3'b111})
		&& ($countones(retire_valid) <= count))
		else $error("retire valid bits %b not contiguous or beyond occupancy %0d",
			retire_valid, count);

	// Stall covers the top slots of the requested group.
	assert property (@(posedge clock) disable iff (reset)
		((stall & ~request_mask) == '0)
		&& (stall_aligned inside {3'b000, 3'b100, 3'b110, 3'b111}))
		else $error("stall bits %b not at the top of a group of %0d", stall, alloc_count);

	assert property (@(posedge clock) reset |=> (stall == '0 && retire_valid == '0))
		else $error("stall or retire active while in reset");

endmodule

bind reorder_buffer core_sva u_sva (
	.clock(clock),
	.reset(reset),
	.count(count),
	.alloc_count(alloc_count),
	.stall(stall),
	.retire(retire)
);

// File: test/clock_gen.sv
`timescale 1ns/1ps

module clock_gen (
	output logic clock,
	output logic reset
);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	// Reset drops just after the tenth rising edge.
	initial begin
		reset = 1'b1;
		repeat (10) @(posedge clock);
		#5;
		reset = 1'b0;
	end

endmodule

// File: rtl/core_top.sv
`timescale 1ns/1ps

module core_top (
	input logic clock,
	input logic reset,
	input logic [core_pkg::WIDTH-1:0] inst_valid,
	input core_pkg::inst_word_t [core_pkg::WIDTH-1:0] inst,
	output logic [core_pkg::WIDTH-1:0] stall,
	output core_pkg::retire_t [core_pkg::WIDTH-1:0] retire
);

	core_pkg::uop_t [core_pkg::WIDTH-1:0] uop;
	core_pkg::complete_t [core_pkg::WIDTH-1:0] complete;
	logic [core_pkg::WIDTH-1:0][core_pkg::ROB_IDX_W-1:0] alloc_tag;
	logic [core_pkg::WIDTH-1:0] issue_valid;
	logic [1:0] alloc_count;

	dispatch_decode u_decode (
		.inst_valid(inst_valid),
		.inst(inst),
		.stall(stall),
		.uop(uop),
		.alloc_count(alloc_count),
		.issue_valid(issue_valid)
	);

	exec_lanes u_exec (
		.clock(clock),
		.reset(reset),
		.issue_valid(issue_valid),
		.uop(uop),
		.alloc_tag(alloc_tag),
		.complete(complete)
	);

	reorder_buffer u_rob (
		.clock(clock),
		.reset(reset),
		.alloc_count(alloc_count),
		.uop(uop),
		.complete(complete),
		.alloc_tag(alloc_tag),
		.stall(stall),
		.retire(retire)
	);

endmodule

// File: rob/reorder_buffer.sv
`timescale 1ns/1ps

module reorder_buffer (
	input logic clock,
	input logic reset,
	input logic [1:0] alloc_count,
	input core_pkg::uop_t [core_pkg::WIDTH-1:0] uop,
	input core_pkg::complete_t [core_pkg::WIDTH-1:0] complete,
	output logic [core_pkg::WIDTH-1:0][core_pkg::ROB_IDX_W-1:0] alloc_tag,
	output logic [core_pkg::WIDTH-1:0] stall,
	output core_pkg::retire_t [core_pkg::WIDTH-1:0] retire
);

	core_pkg::rob_entry_t entries [core_pkg::ROB_DEPTH];
	core_pkg::rob_entry_t entries_next [core_pkg::ROB_DEPTH];

	core_pkg::rob_tag_t head;
	core_pkg::rob_tag_t tail;
	core_pkg::rob_cnt_t count;
	core_pkg::rob_cnt_t count_next;
	core_pkg::rob_cnt_t free_slots;

	logic [1:0] retire_n;
	logic [1:0] accept_n;

	// Run of COMPLETE entries at head, up to three.
	always_comb begin
		core_pkg::rob_tag_t idx;
		retire_n = 2'd0;
		for (int i = 0; i < core_pkg::WIDTH; i++) begin
			idx = head + core_pkg::rob_tag_t'(i);
			if (retire_n == 2'(i) && entries[idx].state == core_pkg::COMPLETE) begin
				retire_n = 2'(i + 1);
			end
		end
	end

	always_comb begin
		core_pkg::rob_tag_t idx;
		for (int i = 0; i < core_pkg::WIDTH; i++) begin
			idx = head + core_pkg::rob_tag_t'(i);
			retire[i].valid = (2'(i) < retire_n);
			retire[i].dest = entries[idx].dest;
			retire[i].writes_reg = entries[idx].writes_reg;
			retire[i].value = entries[idx].value;
		end
	end

	// Entries leaving this cycle are already counted as free.
	assign free_slots = core_pkg::rob_cnt_t'(core_pkg::ROB_DEPTH) - count
		+ core_pkg::rob_cnt_t'(retire_n);

	always_comb begin
		if (core_pkg::rob_cnt_t'(alloc_count) <= free_slots) begin
			accept_n = alloc_count;
		end else begin
			accept_n = free_slots[1:0];
		end
	end

	always_comb begin
		for (int i = 0; i < core_pkg::WIDTH; i++) begin
			alloc_tag[i] = tail + core_pkg::rob_tag_t'(i);
			stall[i] = (2'(i) < alloc_count) && (2'(i) >= accept_n);
		end
	end

	assign count_next = count - core_pkg::rob_cnt_t'(retire_n)
		+ core_pkg::rob_cnt_t'(accept_n);

	// Retire, then allocate, then apply completions.
	always_comb begin
		core_pkg::rob_tag_t idx;
		entries_next = entries;
		for (int i = 0; i < core_pkg::WIDTH; i++) begin
			idx = head + core_pkg::rob_tag_t'(i);
			if (2'(i) < retire_n) begin
				entries_next[idx].state = core_pkg::EMPTY;
				entries_next[idx].completed = 1'b0;
			end
		end
		for (int i = 0; i < core_pkg::WIDTH; i++) begin
			idx = alloc_tag[i];
			if (2'(i) < accept_n) begin
				entries_next[idx].dest = uop[i].dest;
				entries_next[idx].writes_reg = uop[i].writes_reg;
				entries_next[idx].value = '0;
				entries_next[idx].completed = 1'b0;
				entries_next[idx].state = core_pkg::INUSE;
			end
		end
		for (int i = 0; i < core_pkg::WIDTH; i++) begin
			idx = complete[i].tag;
			if (complete[i].valid) begin
				entries_next[idx].value = complete[i].value;
				entries_next[idx].completed = 1'b1;
				entries_next[idx].state = core_pkg::COMPLETE;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			head <= '0;
			tail <= '0;
			count <= '0;
		end else begin
			head <= head + core_pkg::rob_tag_t'(retire_n);
			tail <= tail + core_pkg::rob_tag_t'(accept_n);
			count <= count_next;
		end
	end

	// Only the state fields are cleared.
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < core_pkg::ROB_DEPTH; i++) begin
				entries[i].state <= core_pkg::EMPTY;
				entries[i].completed <= 1'b0;
			end
		end else begin
			for (int i = 0; i < core_pkg::ROB_DEPTH; i++) begin
				entries[i] <= entries_next[i];
			end
		end
	end

endmodule

// File: rtl/exec_lanes.sv
`timescale 1ns/1ps

module exec_lanes (
	input logic clock,
	input logic reset,
	input logic [core_pkg::WIDTH-1:0] issue_valid,
	input core_pkg::uop_t [core_pkg::WIDTH-1:0] uop,
	input logic [core_pkg::WIDTH-1:0][core_pkg::ROB_IDX_W-1:0] alloc_tag,
	output core_pkg::complete_t [core_pkg::WIDTH-1:0] complete
);

	function automatic logic [core_pkg::DATA_W-1:0] alu(input core_pkg::uop_t u);
		logic [core_pkg::DATA_W-1:0] result;
		case (u.alu_op)
			core_pkg::ADD: result = u.operand_a + u.operand_b;
			core_pkg::SUB: result = u.operand_a - u.operand_b;
			core_pkg::AND: result = u.operand_a & u.operand_b;
			core_pkg::SHL: result = u.operand_a << u.operand_b[2:0];
			default: result = '0;
		endcase
		return result;
	endfunction

	// Lane k is k+1 stages deep.
	for (genvar k = 0; k < core_pkg::WIDTH; k++) begin : g_lane
		logic [k:0] valid_q;
		core_pkg::rob_tag_t [k:0] tag_q;
		logic [k:0][core_pkg::DATA_W-1:0] value_q;

		always_ff @(posedge clock) begin
			if (reset) begin
				valid_q <= '0;
			end else begin
				valid_q[0] <= issue_valid[k];
				for (int s = 1; s <= k; s++) begin
					valid_q[s] <= valid_q[s-1];
				end
			end
		end

		always_ff @(posedge clock) begin
			if (issue_valid[k]) begin
				tag_q[0] <= alloc_tag[k];
				value_q[0] <= alu(uop[k]);
			end
			for (int s = 1; s <= k; s++) begin
				tag_q[s] <= tag_q[s-1];
				value_q[s] <= value_q[s-1];
			end
		end

		// Last stage reports back to the reorder buffer.
		assign complete[k].valid = valid_q[k];
		assign complete[k].tag = tag_q[k];
		assign complete[k].value = value_q[k];
	end

endmodule

// File: rtl/dispatch_decode.sv
`timescale 1ns/1ps

module dispatch_decode (
	input logic [core_pkg::WIDTH-1:0] inst_valid,
	input core_pkg::inst_word_t [core_pkg::WIDTH-1:0] inst,
	input logic [core_pkg::WIDTH-1:0] stall,
	output core_pkg::uop_t [core_pkg::WIDTH-1:0] uop,
	output logic [1:0] alloc_count,
	output logic [core_pkg::WIDTH-1:0] issue_valid
);

	logic [core_pkg::WIDTH-1:0] live;

	function automatic core_pkg::alu_op_t decode_op(input logic [1:0] opcode);
		core_pkg::alu_op_t op;
		case (opcode)
			2'b00: op = core_pkg::ADD;
			2'b01: op = core_pkg::SUB;
			2'b10: op = core_pkg::AND;
			default: op = core_pkg::SHL;
		endcase
		return op;
	endfunction

	// Only the run of valid slots starting at slot 0 counts.
	always_comb begin
		logic run;
		run = 1'b1;
		for (int i = 0; i < core_pkg::WIDTH; i++) begin
			run = run & inst_valid[i];
			live[i] = run;
		end
	end

	always_comb begin
		alloc_count = 2'd0;
		for (int i = 0; i < core_pkg::WIDTH; i++) begin
			if (live[i]) begin
				alloc_count = alloc_count + 2'd1;
			end
		end
	end

	assign issue_valid = live & ~stall;

	always_comb begin
		for (int i = 0; i < core_pkg::WIDTH; i++) begin
			uop[i].alu_op = decode_op(inst[i].opcode);
			uop[i].dest = inst[i].dest;
			// Register 0 is never written.
			uop[i].writes_reg = (inst[i].dest != '0);
			uop[i].operand_a = inst[i].imm_a;
			uop[i].operand_b = inst[i].imm_b;
		end
	end

endmodule

// File: common/core_pkg.sv
package core_pkg;

	// Slots per cycle for dispatch, complete and retire.
	localparam int WIDTH = 3;
	localparam int ROB_DEPTH = 8;
	localparam int ROB_IDX_W = 3;
	localparam int DATA_W = 9;
	localparam int DEST_W = 4;

	typedef logic [ROB_IDX_W-1:0] rob_tag_t;
	// Occupancy needs one more bit than a tag.
	typedef logic [ROB_IDX_W:0] rob_cnt_t;

	typedef enum logic [1:0] {
		ADD = 2'b00,
		SUB = 2'b01,
		AND = 2'b10,
		SHL = 2'b11
	} alu_op_t;

	typedef enum logic [1:0] {
		EMPTY = 2'b00,
		INUSE = 2'b01,
		COMPLETE = 2'b10
	} rob_state_t;

	// Instruction word as it arrives, 24 bits.
	typedef struct packed {
		logic [1:0] opcode;
		logic [DEST_W-1:0] dest;
		logic [DATA_W-1:0] imm_a;
		logic [DATA_W-1:0] imm_b;
	} inst_word_t;

	typedef struct packed {
		alu_op_t alu_op;
		logic [DEST_W-1:0] dest;
		logic writes_reg;
		logic [DATA_W-1:0] operand_a;
		logic [DATA_W-1:0] operand_b;
	} uop_t;

	typedef struct packed {
		logic [DEST_W-1:0] dest;
		logic writes_reg;
		logic [DATA_W-1:0] value;
		logic completed;
		rob_state_t state;
	} rob_entry_t;

	typedef struct packed {
		logic valid;
		rob_tag_t tag;
		logic [DATA_W-1:0] value;
	} complete_t;

	typedef struct packed {
		logic valid;
		logic [DEST_W-1:0] dest;
		logic writes_reg;
		logic [DATA_W-1:0] value;
	} retire_t;

endpackage
